// File: Bender.yml
package:
  name: cache_subsystem

sources:
  - rtl/cache_pkg.sv
  - rtl/l1_cache.sv
  - rtl/mem_arbiter.sv
  - rtl/backing_mem.sv
  - rtl/cache_subsystem.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_cache_subsystem.sv

// File: rtl/backing_mem.sv
`timescale 1ns/1ps
`default_nettype none

module backing_mem #(
    parameter int MEM_LATENCY = cache_pkg::DEF_MEM_LATENCY
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            valid_i,
    input  logic                            we_i,
    input  logic [cache_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic [cache_pkg::STRB_WIDTH-1:0] be_i,
    output logic                            rvalid_o,
    output logic [cache_pkg::DATA_WIDTH-1:0] rdata_o
);

    logic [cache_pkg::DATA_WIDTH-1:0] mem_q [cache_pkg::MEM_DEPTH];

    // Read pipeline, one stage per cycle of latency
    logic [MEM_LATENCY-1:0]           vld_sr_q;
    logic [cache_pkg::DATA_WIDTH-1:0] data_sr_q [MEM_LATENCY];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < cache_pkg::MEM_DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (valid_i && we_i) begin
            for (int b = 0; b < cache_pkg::STRB_WIDTH; b++) begin
                if (be_i[b]) begin
                    mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_sr_q <= '0;
        end else begin
            vld_sr_q[0] <= valid_i && !we_i;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                vld_sr_q[i] <= vld_sr_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_sr_q[0] <= mem_q[addr_i];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_sr_q[i] <= data_sr_q[i-1];
        end
    end

    assign rvalid_o = vld_sr_q[MEM_LATENCY-1];
    assign rdata_o  = data_sr_q[MEM_LATENCY-1];

    // Arbiter keeps one transaction in flight
    single_txn_a: assert property (@(posedge clk) disable iff (rst)
        valid_i |-> (vld_sr_q == '0))
        else $error("memory strobe while a read is in flight");

endmodule

`default_nettype wire

// File: rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Word address and data geometry
    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // Backing memory holds every word address
    localparam int MEM_DEPTH = 2 ** ADDR_WIDTH;

    // Default cache geometry
    localparam int DEF_NUM_SETS = 16;
    localparam int DEF_NUM_WAYS = 4;

    // Read latency of the shared memory in cycles
    localparam int DEF_MEM_LATENCY = 3;

    // Requesters sharing the memory
    localparam int NUM_PORTS = 2;
    localparam int PORT_IDX_WIDTH = $clog2(NUM_PORTS);

endpackage

`default_nettype wire

// File: rtl/cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem #(
    parameter int NUM_SETS    = cache_pkg::DEF_NUM_SETS,
    parameter int NUM_WAYS    = cache_pkg::DEF_NUM_WAYS,
    parameter int MEM_LATENCY = cache_pkg::DEF_MEM_LATENCY
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [cache_pkg::NUM_PORTS-1:0]                      req_i,
    input  logic [cache_pkg::NUM_PORTS-1:0]                      we_i,
    input  logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::STRB_WIDTH-1:0] be_i,
    output logic [cache_pkg::NUM_PORTS-1:0]                      ack_o,
    output logic [cache_pkg::NUM_PORTS-1:0]                      hit_o,
    output logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::DATA_WIDTH-1:0] rdata_o
);

    // Cache side of the arbiter
    logic [cache_pkg::NUM_PORTS-1:0]                           mem_req;
    logic [cache_pkg::NUM_PORTS-1:0]                           mem_we;
    logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::ADDR_WIDTH-1:0] mem_addr;
    logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::DATA_WIDTH-1:0] mem_wdata;
    logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::STRB_WIDTH-1:0] mem_be;
    logic [cache_pkg::NUM_PORTS-1:0]                           mem_gnt;
    logic [cache_pkg::NUM_PORTS-1:0]                           fill_valid;
    logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::DATA_WIDTH-1:0] fill_data;

    // Memory side of the arbiter
    logic                             bm_valid;
    logic                             bm_we;
    logic [cache_pkg::ADDR_WIDTH-1:0] bm_addr;
    logic [cache_pkg::DATA_WIDTH-1:0] bm_wdata;
    logic [cache_pkg::STRB_WIDTH-1:0] bm_be;
    logic                             bm_rvalid;
    logic [cache_pkg::DATA_WIDTH-1:0] bm_rdata;

    for (genvar p = 0; p < cache_pkg::NUM_PORTS; p++) begin : gen_port
        l1_cache #(
            .NUM_SETS (NUM_SETS),
            .NUM_WAYS (NUM_WAYS)
        ) l1_cache_i (
            .clk          (clk),
            .rst          (rst),
            .req_i        (req_i[p]),
            .we_i         (we_i[p]),
            .addr_i       (addr_i[p]),
            .wdata_i      (wdata_i[p]),
            .be_i         (be_i[p]),
            .ack_o        (ack_o[p]),
            .hit_o        (hit_o[p]),
            .rdata_o      (rdata_o[p]),
            .mem_req_o    (mem_req[p]),
            .mem_we_o     (mem_we[p]),
            .mem_addr_o   (mem_addr[p]),
            .mem_wdata_o  (mem_wdata[p]),
            .mem_be_o     (mem_be[p]),
            .mem_gnt_i    (mem_gnt[p]),
            .fill_valid_i (fill_valid[p]),
            .fill_data_i  (fill_data[p])
        );
    end

    mem_arbiter #(
        .MEM_LATENCY (MEM_LATENCY)
    ) mem_arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .req_i        (mem_req),
        .we_i         (mem_we),
        .addr_i       (mem_addr),
        .wdata_i      (mem_wdata),
        .be_i         (mem_be),
        .gnt_o        (mem_gnt),
        .fill_valid_o (fill_valid),
        .fill_data_o  (fill_data),
        .mem_valid_o  (bm_valid),
        .mem_we_o     (bm_we),
        .mem_addr_o   (bm_addr),
        .mem_wdata_o  (bm_wdata),
        .mem_be_o     (bm_be),
        .mem_rvalid_i (bm_rvalid),
        .mem_rdata_i  (bm_rdata)
    );

    backing_mem #(
        .MEM_LATENCY (MEM_LATENCY)
    ) backing_mem_i (
        .clk      (clk),
        .rst      (rst),
        .valid_i  (bm_valid),
        .we_i     (bm_we),
        .addr_i   (bm_addr),
        .wdata_i  (bm_wdata),
        .be_i     (bm_be),
        .rvalid_o (bm_rvalid),
        .rdata_o  (bm_rdata)
    );

endmodule

`default_nettype wire

// File: rtl/l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

module l1_cache #(
    parameter int NUM_SETS = cache_pkg::DEF_NUM_SETS,
    parameter int NUM_WAYS = cache_pkg::DEF_NUM_WAYS
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            req_i,
    input  logic                            we_i,
    input  logic [cache_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic [cache_pkg::STRB_WIDTH-1:0] be_i,
    output logic                            ack_o,
    output logic                            hit_o,
    output logic [cache_pkg::DATA_WIDTH-1:0] rdata_o,
    output logic                            mem_req_o,
    output logic                            mem_we_o,
    output logic [cache_pkg::ADDR_WIDTH-1:0] mem_addr_o,
    output logic [cache_pkg::DATA_WIDTH-1:0] mem_wdata_o,
    output logic [cache_pkg::STRB_WIDTH-1:0] mem_be_o,
    input  logic                            mem_gnt_i,
    input  logic                            fill_valid_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0] fill_data_i
);

    localparam int SET_W = $clog2(NUM_SETS);
    localparam int TAG_W = cache_pkg::ADDR_WIDTH - SET_W;
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    typedef enum logic [2:0] {IDLE, LOOKUP, MISS_WAIT, WRITE_WAIT, RESP} state_t;

    logic [NUM_WAYS-1:0]             valid_q [NUM_SETS];
    logic [TAG_W-1:0]                tag_q   [NUM_SETS][NUM_WAYS];
    logic [cache_pkg::DATA_WIDTH-1:0] data_q [NUM_SETS][NUM_WAYS];
    logic [WAY_W-1:0]                rank_q  [NUM_SETS][NUM_WAYS];

    state_t                          state_q;
    logic                            req_pend_q;
    logic                            hit_q;
    logic [WAY_W-1:0]                hit_way_q;
    logic [WAY_W-1:0]                victim_q;
    logic [cache_pkg::DATA_WIDTH-1:0] rdata_q;

    logic [SET_W-1:0]                set_idx;
    logic [TAG_W-1:0]                tag;
    logic                            hit_now;
    logic [WAY_W-1:0]                hit_way;
    logic [cache_pkg::DATA_WIDTH-1:0] hit_data;
    logic                            found_free;
    logic [WAY_W-1:0]                victim_way;
    logic                            rd_hit_en;
    logic                            wr_hit_en;
    logic                            fill_en;
    logic                            touch_en;
    logic [WAY_W-1:0]                touch_way;

    // Requester holds the address, so it indexes the arrays in every state
    assign set_idx = addr_i[SET_W-1:0];
    assign tag     = addr_i[cache_pkg::ADDR_WIDTH-1:SET_W];

    always_comb begin
        hit_now  = 1'b0;
        hit_way  = '0;
        hit_data = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[set_idx][w] && (tag_q[set_idx][w] == tag)) begin
                hit_now  = 1'b1;
                hit_way  = WAY_W'(w);
                hit_data = data_q[set_idx][w];
            end
        end
    end

    // First free way, else lowest rank
    always_comb begin
        found_free = 1'b0;
        victim_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!found_free && !valid_q[set_idx][w]) begin
                found_free = 1'b1;
                victim_way = WAY_W'(w);
            end
        end
        if (!found_free) begin
            for (int w = 1; w < NUM_WAYS; w++) begin
                if (rank_q[set_idx][w] < rank_q[set_idx][victim_way]) begin
                    victim_way = WAY_W'(w);
                end
            end
        end
    end

    assign rd_hit_en = (state_q == IDLE) && req_i && !we_i && hit_now;
    assign wr_hit_en = (state_q == WRITE_WAIT) && mem_gnt_i && hit_q;
    assign fill_en   = (state_q == MISS_WAIT) && fill_valid_i;
    assign touch_en  = rd_hit_en || wr_hit_en || fill_en;
    assign touch_way = rd_hit_en ? hit_way : (fill_en ? victim_q : hit_way_q);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q    <= IDLE;
            req_pend_q <= 1'b0;
            hit_q      <= 1'b0;
            hit_way_q  <= '0;
            victim_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        hit_q     <= hit_now;
                        hit_way_q <= hit_way;
                        state_q   <= rd_hit_en ? RESP : LOOKUP;
                    end
                end
                LOOKUP: begin
                    victim_q   <= victim_way;
                    req_pend_q <= 1'b1;
                    state_q    <= we_i ? WRITE_WAIT : MISS_WAIT;
                end
                MISS_WAIT: begin
                    if (mem_gnt_i) begin
                        req_pend_q <= 1'b0;
                    end
                    if (fill_valid_i) begin
                        state_q <= RESP;
                    end
                end
                WRITE_WAIT: begin
                    if (mem_gnt_i) begin
                        req_pend_q <= 1'b0;
                        state_q    <= RESP;
                    end
                end
                RESP:    state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                for (int w = 0; w < NUM_WAYS; w++) begin
                    rank_q[s][w] <= '0;
                end
            end
        end else begin
            if (fill_en) begin
                valid_q[set_idx][victim_q] <= 1'b1;
            end
            // Touched way becomes most recent, ranks above it move down
            if (touch_en) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    if (WAY_W'(w) == touch_way) begin
                        rank_q[set_idx][w] <= WAY_W'(NUM_WAYS - 1);
                    end else if (rank_q[set_idx][w] > rank_q[set_idx][touch_way]) begin
                        rank_q[set_idx][w] <= rank_q[set_idx][w] - 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[set_idx][victim_q]  <= tag;
            data_q[set_idx][victim_q] <= fill_data_i;
            rdata_q                   <= fill_data_i;
        end
        if (rd_hit_en) begin
            rdata_q <= hit_data;
        end
        if (wr_hit_en) begin
            for (int b = 0; b < cache_pkg::STRB_WIDTH; b++) begin
                if (be_i[b]) begin
                    data_q[set_idx][hit_way_q][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    assign ack_o   = (state_q == RESP);
    assign hit_o   = (state_q == RESP) && hit_q;
    assign rdata_o = rdata_q;

    // Memory request follows the held requester fields
    assign mem_req_o   = req_pend_q;
    assign mem_we_o    = we_i;
    assign mem_addr_o  = addr_i;
    assign mem_wdata_o = wdata_i;
    assign mem_be_o    = be_i;

    req_held_a: assert property (@(posedge clk) disable iff (rst)
        req_i && !ack_o |=> req_i)
        else $error("req_i dropped before ack_o");

    mem_req_held_a: assert property (@(posedge clk) disable iff (rst)
        mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o))
        else $error("memory request changed before mem_gnt_i");

endmodule

`default_nettype wire

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
    parameter int MEM_LATENCY = cache_pkg::DEF_MEM_LATENCY
) (
    input  logic                                                 clk,
    input  logic                                                 rst,
    input  logic [cache_pkg::NUM_PORTS-1:0]                      req_i,
    input  logic [cache_pkg::NUM_PORTS-1:0]                      we_i,
    input  logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::DATA_WIDTH-1:0] wdata_i,
    input  logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::STRB_WIDTH-1:0] be_i,
    output logic [cache_pkg::NUM_PORTS-1:0]                      gnt_o,
    output logic [cache_pkg::NUM_PORTS-1:0]                      fill_valid_o,
    output logic [cache_pkg::NUM_PORTS-1:0][cache_pkg::DATA_WIDTH-1:0] fill_data_o,
    output logic                                                 mem_valid_o,
    output logic                                                 mem_we_o,
    output logic [cache_pkg::ADDR_WIDTH-1:0]                     mem_addr_o,
    output logic [cache_pkg::DATA_WIDTH-1:0]                     mem_wdata_o,
    output logic [cache_pkg::STRB_WIDTH-1:0]                     mem_be_o,
    input  logic                                                 mem_rvalid_i,
    input  logic [cache_pkg::DATA_WIDTH-1:0]                     mem_rdata_i
);

    localparam int NP = cache_pkg::NUM_PORTS;
    localparam int PW = cache_pkg::PORT_IDX_WIDTH;

    // rr_q is the port with the highest priority
    logic [PW-1:0] rr_q;
    logic [PW-1:0] owner_q;
    logic          busy_q;
    logic          busy_we_q;
    logic [PW-1:0] pick;
    logic          found;

    always_comb begin : pick_next
        int idx;
        found = 1'b0;
        pick  = rr_q;
        for (int i = 0; i < NP; i++) begin
            idx = int'(rr_q) + i;
            if (idx >= NP) begin
                idx = idx - NP;
            end
            if (!found && req_i[idx]) begin
                found = 1'b1;
                pick  = PW'(idx);
            end
        end
    end

    always_comb begin
        gnt_o = '0;
        if (!busy_q && found) begin
            gnt_o[pick] = 1'b1;
        end
    end

    assign mem_valid_o = |gnt_o;
    assign mem_we_o    = we_i[pick];
    assign mem_addr_o  = addr_i[pick];
    assign mem_wdata_o = wdata_i[pick];
    assign mem_be_o    = be_i[pick];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rr_q      <= '0;
            owner_q   <= '0;
            busy_q    <= 1'b0;
            busy_we_q <= 1'b0;
        end else if (mem_valid_o) begin
            busy_q    <= 1'b1;
            busy_we_q <= we_i[pick];
            owner_q   <= pick;
            rr_q      <= (int'(pick) == NP - 1) ? '0 : pick + 1'b1;
        end else if (busy_q && (busy_we_q || mem_rvalid_i)) begin
            // Writes free the memory one cycle after the strobe
            busy_q <= 1'b0;
        end
    end

    always_comb begin
        fill_valid_o = '0;
        fill_valid_o[owner_q] = busy_q && mem_rvalid_i;
        for (int p = 0; p < NP; p++) begin
            fill_data_o[p] = mem_rdata_i;
        end
    end

    gnt_onehot_a: assert property (@(posedge clk) disable iff (rst) $onehot0(gnt_o))
        else $error("more than one grant in a cycle");

    read_latency_a: assert property (@(posedge clk) disable iff (rst)
        mem_valid_o && !mem_we_o |-> ##MEM_LATENCY mem_rvalid_i)
        else $error("memory read response missing");

endmodule

`default_nettype wire

// File: tests/tb_cache_model.svh
`ifndef TB_CACHE_MODEL_SVH
`define TB_CACHE_MODEL_SVH

// Reference memory, plus tag and LRU state of each port's cache
logic [cache_pkg::DATA_WIDTH-1:0] mem_model [cache_pkg::MEM_DEPTH];
logic m_valid [cache_pkg::NUM_PORTS][SETS][WAYS];
int   m_tag   [cache_pkg::NUM_PORTS][SETS][WAYS];
int   m_rank  [cache_pkg::NUM_PORTS][SETS][WAYS];
int   err_count;
int   check_count;

function automatic void clear_model();
    for (int i = 0; i < cache_pkg::MEM_DEPTH; i++) begin
        mem_model[i] = '0;
    end
    for (int p = 0; p < cache_pkg::NUM_PORTS; p++) begin
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                m_valid[p][s][w] = 1'b0;
                m_tag[p][s][w]   = 0;
                m_rank[p][s][w]  = 0;
            end
        end
    end
endfunction

// Way holding the address, or -1 on a miss
function automatic int find_way(input int p, input int a);
    find_way = -1;
    for (int w = 0; w < WAYS; w++) begin
        if (m_valid[p][a % SETS][w] && (m_tag[p][a % SETS][w] == a / SETS)) begin
            find_way = w;
        end
    end
endfunction

// Most recent way gets the top rank, higher ranks step down
function automatic void touch_way(input int p, input int s, input int way);
    int old;
    old = m_rank[p][s][way];
    for (int w = 0; w < WAYS; w++) begin
        if (m_rank[p][s][w] > old) begin
            m_rank[p][s][w] = m_rank[p][s][w] - 1;
        end
    end
    m_rank[p][s][way] = WAYS - 1;
endfunction

function automatic void fill_line(input int p, input int a);
    int s;
    int victim;
    s      = a % SETS;
    victim = -1;
    for (int w = WAYS - 1; w >= 0; w--) begin
        if (!m_valid[p][s][w]) begin
            victim = w;
        end
    end
    // No free way, so the least recently used one goes
    if (victim < 0) begin
        victim = 0;
        for (int w = 1; w < WAYS; w++) begin
            if (m_rank[p][s][w] < m_rank[p][s][victim]) begin
                victim = w;
            end
        end
    end
    m_valid[p][s][victim] = 1'b1;
    m_tag[p][s][victim]   = a / SETS;
    touch_way(p, s, victim);
endfunction

function automatic void write_model(input int a, input logic [cache_pkg::DATA_WIDTH-1:0] d,
                                    input logic [cache_pkg::STRB_WIDTH-1:0] b);
    for (int i = 0; i < cache_pkg::STRB_WIDTH; i++) begin
        if (b[i]) begin
            mem_model[a][i*8 +: 8] = d[i*8 +: 8];
        end
    end
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
    end
endtask

`endif

// File: tests/tb_cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_subsystem;

    localparam int NP       = cache_pkg::NUM_PORTS;
    localparam int SETS     = cache_pkg::DEF_NUM_SETS;
    localparam int WAYS     = cache_pkg::DEF_NUM_WAYS;
    localparam int HALF     = cache_pkg::MEM_DEPTH / 2;
    localparam int NUM_RAND = 80;
    localparam int TIMEOUT  = 200;

    logic                                       clk;
    logic                                       rst;
    logic [NP-1:0]                              req;
    logic [NP-1:0]                              we;
    logic [NP-1:0][cache_pkg::ADDR_WIDTH-1:0]   addr;
    logic [NP-1:0][cache_pkg::DATA_WIDTH-1:0]   wdata;
    logic [NP-1:0][cache_pkg::STRB_WIDTH-1:0]   be;
    logic [NP-1:0]                              ack;
    logic [NP-1:0]                              hit;
    logic [NP-1:0][cache_pkg::DATA_WIDTH-1:0]   rdata;

    // Random operations, drawn before the ports start
    logic                             rnd_we    [NP][NUM_RAND];
    int                               rnd_addr  [NP][NUM_RAND];
    logic [cache_pkg::DATA_WIDTH-1:0] rnd_wdata [NP][NUM_RAND];
    logic [cache_pkg::STRB_WIDTH-1:0] rnd_be    [NP][NUM_RAND];
    logic                             hung      [NP];
    int                               seed;

    `include "tb_cache_model.svh"

    cache_subsystem #(
        .NUM_SETS    (SETS),
        .NUM_WAYS    (WAYS),
        .MEM_LATENCY (cache_pkg::DEF_MEM_LATENCY)
    ) cache_subsystem_i (
        .clk     (clk),
        .rst     (rst),
        .req_i   (req),
        .we_i    (we),
        .addr_i  (addr),
        .wdata_i (wdata),
        .be_i    (be),
        .ack_o   (ack),
        .hit_o   (hit),
        .rdata_o (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic access(input int p, input logic wr, input int a,
                          input logic [cache_pkg::DATA_WIDTH-1:0] d,
                          input logic [cache_pkg::STRB_WIDTH-1:0] b);
        int                               way;
        int                               cyc;
        logic [cache_pkg::DATA_WIDTH-1:0] exp_data;
        way      = find_way(p, a);
        exp_data = mem_model[a];
        if (hung[p]) begin
            return;
        end
        @(posedge clk);
        req[p]   <= 1'b1;
        we[p]    <= wr;
        addr[p]  <= cache_pkg::ADDR_WIDTH'(a);
        wdata[p] <= d;
        be[p]    <= b;
        @(posedge clk);
        cyc = 1;
        while (!ack[p] && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        req[p] <= 1'b0;
        if (!ack[p]) begin
            $display("Port %0d hung: no ack_o within %0d cycles", p, TIMEOUT);
            err_count++;
            hung[p] = 1'b1;
            return;
        end
        check_value($sformatf("hit_o[%0d]", p), hit[p], way >= 0);
        if (!wr) begin
            check_value($sformatf("rdata_o[%0d]", p), rdata[p], exp_data);
            if (way >= 0) begin
                check_value($sformatf("read hit latency[%0d]", p), cyc, 2);
            end
        end
        // Write misses leave the cache untouched
        if (way >= 0) begin
            touch_way(p, a % SETS, way);
        end else if (!wr) begin
            fill_line(p, a);
        end
        if (wr) begin
            write_model(a, d, b);
        end
    endtask

    task automatic run_port(input int p);
        int base;
        base = p * HALF;
        access(p, 1'b0, base + 16, '0, '0);
        access(p, 1'b0, base + 16, '0, '0);
        access(p, 1'b1, base + 16, rnd_wdata[p][0], 4'b0101);
        access(p, 1'b0, base + 16, '0, '0);
        // Both ports contend here with their own data
        access(p, 1'b1, base + 37, rnd_wdata[p][1], 4'b1110);
        access(p, 1'b0, base + 37, '0, '0);
        // One tag more than ways in set 7, with the second tag left as LRU
        for (int k = 0; k < WAYS; k++) begin
            access(p, 1'b0, base + 7 + k * SETS, '0, '0);
        end
        access(p, 1'b0, base + 7, '0, '0);
        access(p, 1'b0, base + 7 + WAYS * SETS, '0, '0);
        for (int k = 0; k <= WAYS; k++) begin
            access(p, 1'b0, base + 7 + k * SETS, '0, '0);
        end
        for (int i = 0; i < NUM_RAND; i++) begin
            access(p, rnd_we[p][i], rnd_addr[p][i], rnd_wdata[p][i], rnd_be[p][i]);
        end
    endtask

    initial begin
        int idx;
        rst         = 1'b1;
        req         = '0;
        we          = '0;
        addr        = '0;
        wdata       = '0;
        be          = '0;
        err_count   = 0;
        check_count = 0;
        clear_model();
        seed = 26;
        // Pool of six tags in each of sets 8 and 9
        for (int p = 0; p < NP; p++) begin
            hung[p] = 1'b0;
            for (int i = 0; i < NUM_RAND; i++) begin
                idx             = ($random(seed) & 32'h7fff_ffff) % 12;
                rnd_addr[p][i]  = p * HALF + 256 + (idx / 2) * SETS + 8 + idx % 2;
                rnd_we[p][i]    = ($random(seed) & 3) == 0;
                rnd_wdata[p][i] = $random(seed);
                rnd_be[p][i]    = $random(seed);
            end
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        fork
            run_port(0);
            run_port(1);
        join
        repeat (2) @(posedge clk);
        $display("Checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+tests
rtl/cache_pkg.sv
rtl/l1_cache.sv
rtl/mem_arbiter.sv
rtl/backing_mem.sv
rtl/cache_subsystem.sv
tests/tb_cache_subsystem.sv
